// File: sources.f
+incdir+hw
hw/dmac_req_pkg.sv
hw/dmac_engine_pkg.sv
hw/dmac_2d_transfer.sv
hw/dmac_row_fifo.sv
hw/dmac_burst_engine.sv
hw/dmac_2d_top.sv
dv/dmac_2d_sva.sv
dv/dmac_2d_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -j 0 -f sources.f --top-module dmac_2d_tb -o sim \
	&& ./obj_dir/sim +verilator+error+limit+100 | grep "All tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: dv/dmac_2d_tb.sv
`include "dmac_params.svh"

module dmac_2d_tb
	import dmac_req_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 2000;

	logic       req_aclk = 1'b0;
	logic       req_aresetn;
	logic       req_valid;
	logic       req_ready;
	dest_addr_t req_dest_address;
	src_addr_t  req_src_address;
	dmac_len_t  req_x_length;
	dmac_len_t  req_y_length;
	dmac_len_t  req_dest_stride;
	dmac_len_t  req_src_stride;
	logic       req_sync_transfer_start;
	logic       req_eot;
	logic       beat_valid;
	logic       beat_ready = 1'b1;
	dest_addr_t beat_dest_address;
	src_addr_t  beat_src_address;
	logic       beat_last;
	logic       beat_sync_transfer_start;

	int   seed = 65;
	logic stall_en = 1'b0;
	int   sent = 0;
	int   eot_total = 0;
	int   beat_total = 0; // Beats since the last req_eot
	int   exp_beats [$];
	int   done_beats [$];

	dmac_2d_top u_dut (.*);

	always #5 req_aclk = ~req_aclk;

	always @(posedge req_aclk) begin
		#1;
		beat_ready = stall_en ? ($random(seed) % 3 != 0) : 1'b1;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	// Per transfer beat totals, closed by each req_eot
	always @(posedge req_aclk) begin
		if (req_eot) begin
			done_beats.push_back(beat_total);
			eot_total++;
			beat_total = 0;
		end
		if (beat_valid && beat_ready)
			beat_total++;
		if (u_dut.u_sva.error_count != 0)
			abort_run("A bound assertion on the DUT failed");
	end

	task automatic send_transfer(input logic [31:0] dest, input logic [31:0] src,
		input int beats, input int rows, input logic [31:0] dstride,
		input logic [31:0] sstride, input logic sync);
		int cycles;
		cycles = 0;
		@(posedge req_aclk);
		#1;
		req_valid               = 1'b1;
		req_dest_address        = dest[31:`DMAC_BEAT_WIDTH_DEST];
		req_src_address         = src[31:`DMAC_BEAT_WIDTH_SRC];
		req_x_length            = dmac_len_t'(beats * (1 << `DMAC_BEAT_WIDTH_DEST) - 1);
		req_y_length            = dmac_len_t'(rows - 1);
		req_dest_stride         = dmac_len_t'(dstride);
		req_src_stride          = dmac_len_t'(sstride);
		req_sync_transfer_start = sync;
		@(posedge req_aclk);
		while (!req_ready) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				abort_run("Timeout while waiting for req_ready");
			@(posedge req_aclk);
		end
		#1;
		req_valid = 1'b0;
		exp_beats.push_back(beats * rows);
		sent++;
	endtask

	task automatic check_done(input string name);
		int cycles;
		int expected;
		int actual;
		cycles = 0;
		while (done_beats.size() < exp_beats.size()) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				abort_run($sformatf("Timeout while waiting for req_eot in %s", name));
			@(posedge req_aclk);
		end
		while (exp_beats.size() != 0) begin
			expected = exp_beats.pop_front();
			actual   = done_beats.pop_front();
			check_value({name, " beat count"}, expected, actual);
		end
		repeat (8) @(posedge req_aclk); // Window for a stray second req_eot
		check_value({name, " req_eot count"}, sent, eot_total);
	endtask

	initial begin
		req_aresetn             = 1'b0;
		req_valid               = 1'b0;
		req_dest_address        = '0;
		req_src_address         = '0;
		req_x_length            = '0;
		req_y_length            = '0;
		req_dest_stride         = '0;
		req_src_stride          = '0;
		req_sync_transfer_start = 1'b0;
		repeat (10) @(posedge req_aclk);
		#1;
		req_aresetn = 1'b1;

		send_transfer(32'h0000_1000, 32'h0008_0000, 4, 1, 32'h0, 32'h0, 1'b1);
		check_done("single_row");
		send_transfer(32'h0001_0000, 32'h0004_0040, 3, 4, 32'h100, 32'h40, 1'b0);
		check_done("multi_row_strides");
		send_transfer(32'h0002_0000, 32'h0005_0000, 2, 3, 32'h80, 32'h200, 1'b1);
		check_done("sync_first_row");

		stall_en = 1'b1;
		send_transfer(32'h0003_0000, 32'h0006_0000, 5, 5, 32'h400, 32'h28, 1'b0);
		check_done("random_stall");

		// Second request goes in as soon as req_ready returns
		send_transfer(32'h0004_0000, 32'h0007_0000, 3, 3, 32'h40, 32'h18, 1'b1);
		send_transfer(32'h0005_0000, 32'h0009_0000, 2, 4, 32'h20, 32'h60, 1'b1);
		check_done("back_to_back");

		if (u_dut.u_sva.error_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run("Bound assertions reported errors");
		end
	end

endmodule

// File: dv/dmac_2d_sva.sv
`include "dmac_params.svh"

module dmac_2d_sva
	import dmac_req_pkg::*;
	import dmac_engine_pkg::*;
(
	input logic       req_aclk,
	input logic       req_aresetn,
	input logic       req_valid,
	input logic       req_ready,
	input dest_addr_t req_dest_address,
	input src_addr_t  req_src_address,
	input dmac_len_t  req_x_length,
	input dmac_len_t  req_y_length,
	input dmac_len_t  req_dest_stride,
	input dmac_len_t  req_src_stride,
	input logic       req_sync_transfer_start,
	input logic       req_eot,
	input logic       row_valid,
	input logic       row_ready,
	input logic       beat_valid,
	input logic       beat_ready,
	input dest_addr_t beat_dest_address,
	input src_addr_t  beat_src_address,
	input logic       beat_last,
	input logic       beat_sync_transfer_start
);

	timeunit 1ns;
	timeprecision 100ps;

	// Accepted transfers, oldest at rd_sel
	dest_addr_t  t_dest [4];
	src_addr_t   t_src [4];
	dest_addr_t  t_dest_step [4];
	src_addr_t   t_src_step [4];
	beat_count_t t_beats [4]; // Beats per row minus one
	dmac_len_t   t_rows [4]; // Rows minus one
	logic        t_sync [4];

	row_id_t     wr_sel;
	row_id_t     rd_sel;
	dmac_len_t   row_idx;
	beat_count_t beat_idx;
	int          eot_owed;
	int          rows_to_issue; // Rows of the newest transfer not yet queued
	int          error_count = 0;

	logic       beat_hs;
	logic       row_done;
	logic       xfer_done;
	dest_addr_t exp_dest;
	src_addr_t  exp_src;

	assign beat_hs   = beat_valid & beat_ready;
	assign row_done  = beat_idx == t_beats[rd_sel];
	assign xfer_done = row_done && row_idx == t_rows[rd_sel];
	assign exp_dest  = t_dest[rd_sel] + dest_addr_t'(row_idx) * t_dest_step[rd_sel] +
		dest_addr_t'(beat_idx);
	assign exp_src   = t_src[rd_sel] + src_addr_t'(row_idx) * t_src_step[rd_sel] +
		src_addr_t'(beat_idx);

	always_ff @(posedge req_aclk) begin
		if (req_aresetn == 1'b0) begin
			wr_sel        <= '0;
			rd_sel        <= '0;
			row_idx       <= '0;
			beat_idx      <= '0;
			eot_owed      <= 0;
			rows_to_issue <= 0;
		end else begin
			if (req_valid && req_ready) begin
				t_dest[wr_sel]      <= req_dest_address;
				t_src[wr_sel]       <= req_src_address;
				t_dest_step[wr_sel] <= dest_addr_t'(req_dest_stride >> `DMAC_BEAT_WIDTH_DEST);
				t_src_step[wr_sel]  <= src_addr_t'(req_src_stride >> `DMAC_BEAT_WIDTH_SRC);
				t_beats[wr_sel]     <= beat_count_t'(req_x_length >> `DMAC_BEAT_WIDTH_DEST);
				t_rows[wr_sel]      <= req_y_length;
				t_sync[wr_sel]      <= req_sync_transfer_start;
				wr_sel              <= wr_sel + row_id_t'(1);
				rows_to_issue       <= int'(req_y_length) + 1;
			end else if (row_valid && row_ready) begin
				rows_to_issue <= rows_to_issue - 1;
			end
			if (beat_hs) begin
				beat_idx <= row_done ? '0 : beat_idx + beat_count_t'(1);
				if (xfer_done) begin
					row_idx <= '0;
					rd_sel  <= rd_sel + row_id_t'(1);
				end else if (row_done) begin
					row_idx <= row_idx + dmac_len_t'(1);
				end
			end
			eot_owed <= eot_owed + int'(beat_hs && xfer_done) - int'(req_eot);
		end
	end

	a_beat_model: assert property (@(posedge req_aclk) disable iff (!req_aresetn)
		beat_valid |-> wr_sel != rd_sel && beat_dest_address == exp_dest &&
			beat_src_address == exp_src && beat_last == row_done &&
			beat_sync_transfer_start == (t_sync[rd_sel] && row_idx == '0))
		else begin
			$error("Beat fields do not follow the 2D address walk");
			error_count++;
		end

	a_beat_hold: assert property (@(posedge req_aclk) disable iff (!req_aresetn)
		beat_valid && !beat_ready |=> beat_valid && $stable(beat_dest_address) &&
			$stable(beat_src_address) && $stable(beat_last) &&
			$stable(beat_sync_transfer_start))
		else begin
			$error("Stalled beat changed or dropped");
			error_count++;
		end

	a_row_start: assert property (@(posedge req_aclk) disable iff (!req_aresetn)
		req_valid && req_ready |=> row_valid)
		else begin
			$error("No row request in the cycle after acceptance");
			error_count++;
		end

	// Splitter takes a new request only once every row of the last one is queued
	a_ready_low: assert property (@(posedge req_aclk) disable iff (!req_aresetn)
		req_ready == (rows_to_issue == 0))
		else begin
			$error("req_ready does not match the rows still to be issued");
			error_count++;
		end

	a_eot_order: assert property (@(posedge req_aclk) disable iff (!req_aresetn)
		req_eot |-> eot_owed > 0)
		else begin
			$error("req_eot without a finished transfer");
			error_count++;
		end

	a_reset_state: assert property (@(posedge req_aclk)
		!req_aresetn |=> req_ready && !row_valid && !beat_valid && !req_eot)
		else begin
			$error("Wrong output state after reset");
			error_count++;
		end

endmodule

bind dmac_2d_top dmac_2d_sva u_sva (.*);

// File: hw/dmac_2d_top.sv
module dmac_2d_top
	import dmac_req_pkg::*;
(
	input  logic       req_aclk,
	input  logic       req_aresetn,

	input  logic       req_valid,
	output logic       req_ready,
	input  dest_addr_t req_dest_address,
	input  src_addr_t  req_src_address,
	input  dmac_len_t  req_x_length,
	input  dmac_len_t  req_y_length,
	input  dmac_len_t  req_dest_stride,
	input  dmac_len_t  req_src_stride,
	input  logic       req_sync_transfer_start,
	output logic       req_eot,

	output logic       beat_valid,
	input  logic       beat_ready,
	output dest_addr_t beat_dest_address,
	output src_addr_t  beat_src_address,
	output logic       beat_last,
	output logic       beat_sync_transfer_start
);

	// Splitter to queue
	logic       row_valid;
	logic       row_ready;
	dest_addr_t row_dest_address;
	src_addr_t  row_src_address;
	dmac_len_t  row_length;
	logic       row_sync_transfer_start;
	logic       row_eot;

	// Queue to engine
	logic       fifo_valid;
	logic       fifo_ready;
	dest_addr_t fifo_dest_address;
	src_addr_t  fifo_src_address;
	dmac_len_t  fifo_length;
	logic       fifo_sync_transfer_start;

	dmac_2d_transfer u_transfer (
		.req_aclk                (req_aclk),
		.req_aresetn             (req_aresetn),
		.req_valid               (req_valid),
		.req_ready               (req_ready),
		.req_dest_address        (req_dest_address),
		.req_src_address         (req_src_address),
		.req_x_length            (req_x_length),
		.req_y_length            (req_y_length),
		.req_dest_stride         (req_dest_stride),
		.req_src_stride          (req_src_stride),
		.req_sync_transfer_start (req_sync_transfer_start),
		.req_eot                 (req_eot),
		.row_valid               (row_valid),
		.row_ready               (row_ready),
		.row_dest_address        (row_dest_address),
		.row_src_address         (row_src_address),
		.row_length              (row_length),
		.row_sync_transfer_start (row_sync_transfer_start),
		.row_eot                 (row_eot)
	);

	dmac_row_fifo u_fifo (
		.req_aclk                 (req_aclk),
		.req_aresetn              (req_aresetn),
		.row_valid                (row_valid),
		.row_ready                (row_ready),
		.row_dest_address         (row_dest_address),
		.row_src_address          (row_src_address),
		.row_length               (row_length),
		.row_sync_transfer_start  (row_sync_transfer_start),
		.fifo_valid               (fifo_valid),
		.fifo_ready               (fifo_ready),
		.fifo_dest_address        (fifo_dest_address),
		.fifo_src_address         (fifo_src_address),
		.fifo_length              (fifo_length),
		.fifo_sync_transfer_start (fifo_sync_transfer_start)
	);

	dmac_burst_engine u_engine (
		.req_aclk                 (req_aclk),
		.req_aresetn              (req_aresetn),
		.fifo_valid               (fifo_valid),
		.fifo_ready               (fifo_ready),
		.fifo_dest_address        (fifo_dest_address),
		.fifo_src_address         (fifo_src_address),
		.fifo_length              (fifo_length),
		.fifo_sync_transfer_start (fifo_sync_transfer_start),
		.beat_valid               (beat_valid),
		.beat_ready               (beat_ready),
		.beat_dest_address        (beat_dest_address),
		.beat_src_address         (beat_src_address),
		.beat_last                (beat_last),
		.beat_sync_transfer_start (beat_sync_transfer_start),
		.row_eot                  (row_eot)
	);

endmodule

// File: hw/dmac_burst_engine.sv
`include "dmac_params.svh"

module dmac_burst_engine
	import dmac_req_pkg::*;
	import dmac_engine_pkg::*;
(
	input  logic       req_aclk,
	input  logic       req_aresetn,

	input  logic       fifo_valid,
	output logic       fifo_ready,
	input  dest_addr_t fifo_dest_address,
	input  src_addr_t  fifo_src_address,
	input  dmac_len_t  fifo_length,
	input  logic       fifo_sync_transfer_start,

	output logic       beat_valid,
	input  logic       beat_ready,
	output dest_addr_t beat_dest_address,
	output src_addr_t  beat_src_address,
	output logic       beat_last,
	output logic       beat_sync_transfer_start,

	output logic       row_eot
);

	engine_state_t state;
	beat_count_t   beats_left;

	assign fifo_ready = state == ENGINE_IDLE;
	assign beat_valid = state == ENGINE_BEATS;
	assign row_eot    = state == ENGINE_EOT; // One cycle after the last beat
	assign beat_last  = beats_left == '0;

	always_ff @(posedge req_aclk) begin
		if (req_aresetn == 1'b0) begin
			state <= ENGINE_IDLE;
		end else begin
			case (state)
			ENGINE_IDLE: begin
				if (fifo_valid)
					state <= ENGINE_BEATS;
			end
			ENGINE_BEATS: begin
				if (beat_ready && beat_last)
					state <= ENGINE_EOT;
			end
			ENGINE_EOT: begin
				state <= ENGINE_IDLE;
			end
			default: begin
				state <= ENGINE_IDLE;
			end
			endcase
		end
	end

	// Row payload and beat walk
	always_ff @(posedge req_aclk) begin
		if (fifo_valid && fifo_ready) begin
			beat_dest_address        <= fifo_dest_address;
			beat_src_address         <= fifo_src_address;
			beats_left               <= fifo_length[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH_DEST];
			beat_sync_transfer_start <= fifo_sync_transfer_start;
		end else if (beat_valid && beat_ready && !beat_last) begin
			beat_dest_address <= beat_dest_address + dest_addr_t'(1);
			beat_src_address  <= beat_src_address + src_addr_t'(1);
			beats_left        <= beats_left - beat_count_t'(1);
		end
	end

endmodule

// File: hw/dmac_row_fifo.sv
`include "dmac_params.svh"

module dmac_row_fifo
	import dmac_req_pkg::*;
(
	input  logic       req_aclk,
	input  logic       req_aresetn,

	input  logic       row_valid,
	output logic       row_ready,
	input  dest_addr_t row_dest_address,
	input  src_addr_t  row_src_address,
	input  dmac_len_t  row_length,
	input  logic       row_sync_transfer_start,

	output logic       fifo_valid,
	input  logic       fifo_ready,
	output dest_addr_t fifo_dest_address,
	output src_addr_t  fifo_src_address,
	output dmac_len_t  fifo_length,
	output logic       fifo_sync_transfer_start
);

	localparam int DEPTH = `DMAC_ROW_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dest_addr_t mem_dest [DEPTH];
	src_addr_t  mem_src [DEPTH];
	dmac_len_t  mem_length [DEPTH];
	logic       mem_sync [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push;
	logic pop;

	assign row_ready  = count != CNT_W'(DEPTH);
	assign fifo_valid = count != '0;
	assign push = row_valid & row_ready;
	assign pop  = fifo_valid & fifo_ready;

	assign fifo_dest_address        = mem_dest[rd_ptr];
	assign fifo_src_address         = mem_src[rd_ptr];
	assign fifo_length              = mem_length[rd_ptr];
	assign fifo_sync_transfer_start = mem_sync[rd_ptr];

	always_ff @(posedge req_aclk) begin
		if (push) begin
			mem_dest[wr_ptr]   <= row_dest_address;
			mem_src[wr_ptr]    <= row_src_address;
			mem_length[wr_ptr] <= row_length;
			mem_sync[wr_ptr]   <= row_sync_transfer_start;
		end
	end

	always_ff @(posedge req_aclk) begin
		if (req_aresetn == 1'b0) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: hw/dmac_2d_transfer.sv
`include "dmac_params.svh"

module dmac_2d_transfer
	import dmac_req_pkg::*;
(
	input  logic       req_aclk,
	input  logic       req_aresetn,

	input  logic       req_valid,
	output logic       req_ready,
	input  dest_addr_t req_dest_address,
	input  src_addr_t  req_src_address,
	input  dmac_len_t  req_x_length,
	input  dmac_len_t  req_y_length,
	input  dmac_len_t  req_dest_stride,
	input  dmac_len_t  req_src_stride,
	input  logic       req_sync_transfer_start,
	output logic       req_eot,

	output logic       row_valid,
	input  logic       row_ready,
	output dest_addr_t row_dest_address,
	output src_addr_t  row_src_address,
	output dmac_len_t  row_length,
	output logic       row_sync_transfer_start,
	input  logic       row_eot
);

	dest_addr_t dest_address;
	src_addr_t  src_address;
	dmac_len_t  x_length;
	dmac_len_t  y_length; // Rows left after the current one
	dmac_len_t  dest_stride;
	dmac_len_t  src_stride;

	row_id_t    req_id; // Next row to issue
	row_id_t    eot_id; // Next row to complete
	logic [3:0] last_req; // Set for the final row of a transfer

	logic req_hs;
	logic row_hs;

	assign req_hs = req_valid & req_ready;
	assign row_hs = row_valid & row_ready;

	assign row_dest_address = dest_address;
	assign row_src_address  = src_address;
	assign row_length       = x_length;

	always_ff @(posedge req_aclk) begin
		if (req_aresetn == 1'b0) begin
			req_ready <= 1'b1;
			row_valid <= 1'b0;
			req_id    <= '0;
			eot_id    <= '0;
			last_req  <= '0;
			req_eot   <= 1'b0;
		end else begin
			if (req_hs) begin
				req_ready <= 1'b0;
				row_valid <= 1'b1;
			end else if (row_hs) begin
				req_id           <= req_id + 1'b1;
				last_req[req_id] <= y_length == '0;
				if (y_length == '0) begin
					row_valid <= 1'b0;
					req_ready <= 1'b1;
				end
			end

			req_eot <= 1'b0;
			if (row_eot) begin
				eot_id  <= eot_id + 1'b1;
				req_eot <= last_req[eot_id];
			end
		end
	end

	always_ff @(posedge req_aclk) begin
		if (req_hs) begin
			dest_address            <= req_dest_address;
			src_address             <= req_src_address;
			x_length                <= req_x_length;
			y_length                <= req_y_length;
			dest_stride             <= req_dest_stride;
			src_stride              <= req_src_stride;
			row_sync_transfer_start <= req_sync_transfer_start;
		end else if (row_hs) begin
			// Strides are in bytes, addresses in beats
			dest_address <= dest_address +
				dest_addr_t'(dest_stride >> `DMAC_BEAT_WIDTH_DEST);
			src_address <= src_address +
				src_addr_t'(src_stride >> `DMAC_BEAT_WIDTH_SRC);
			y_length                <= y_length - dmac_len_t'(1);
			row_sync_transfer_start <= 1'b0; // Only the first row carries sync
		end
	end

endmodule

// File: hw/dmac_engine_pkg.sv
`include "dmac_params.svh"

package dmac_engine_pkg;

	typedef enum logic [1:0] {
		ENGINE_IDLE,
		ENGINE_BEATS,
		ENGINE_EOT
	} engine_state_t;

	// Beats left in the row, minus one
	typedef logic [`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH_DEST] beat_count_t;

endpackage

// File: hw/dmac_req_pkg.sv
`include "dmac_params.svh"

package dmac_req_pkg;

	// Beat aligned addresses, byte offset bits dropped
	typedef logic [31:`DMAC_BEAT_WIDTH_DEST] dest_addr_t;
	typedef logic [31:`DMAC_BEAT_WIDTH_SRC] src_addr_t;

	// Byte lengths and strides
	typedef logic [`DMAC_LENGTH_WIDTH-1:0] dmac_len_t;

	// Tag of an outstanding row
	typedef logic [1:0] row_id_t;

endpackage

// File: hw/dmac_params.svh
`ifndef DMAC_PARAMS_SVH
`define DMAC_PARAMS_SVH

// Lengths and strides, N means N+1 bytes
`define DMAC_LENGTH_WIDTH 24

// Log2 of bytes per beat
`define DMAC_BEAT_WIDTH_SRC 3
`define DMAC_BEAT_WIDTH_DEST 3

// Keep at 3 or below: queue plus engine may hold four rows at most,
// which is the reach of the 2-bit row id in the splitter
`define DMAC_ROW_FIFO_DEPTH 2

`endif
